/* hdl/matmul_consts.svh */
// **************************************************
// Fixed dimensions and widths of the tiled matrix
// multiplier, included by the packages and the RTL
// **************************************************
`ifndef MATMUL_CONSTS_SVH
`define MATMUL_CONSTS_SVH

// Matrix and tile geometry
`define MM_TOTAL_DIM   4
`define MM_TILE_DIM    2
`define MM_TILE_DEPTH  (`MM_TOTAL_DIM / `MM_TILE_DIM)
`define MM_B_TILES     4

// Input elements, signed fixed point
`define MM_A_WIDTH     8
`define MM_B_WIDTH     8
`define MM_IN_FRAC     1

// Sum of MM_TILE_DIM products of two 8-bit values
`define MM_PROD_WIDTH  17
// One extra bit for summing MM_TILE_DEPTH tile products
`define MM_ACC_WIDTH   18

// Result elements after the output cast
`define MM_OUT_WIDTH   16
`define MM_OUT_FRAC    2

`endif

/* hdl/matmul_data_pkg.sv */
// **************************************************
// Element and tile types of the matrix data path,
// from the A and B inputs down to the C results
// **************************************************
`include "matmul_consts.svh"

package matmul_data_pkg;

  // Input elements with one fractional bit
  typedef logic signed [`MM_A_WIDTH-1:0] a_elem_t;
  typedef logic signed [`MM_B_WIDTH-1:0] b_elem_t;

  // Full precision sums, two fractional bits
  typedef logic signed [`MM_PROD_WIDTH-1:0] prod_elem_t;
  typedef logic signed [`MM_ACC_WIDTH-1:0] acc_elem_t;

  // Output element after shift and saturation
  typedef logic signed [`MM_OUT_WIDTH-1:0] c_elem_t;

  // Tiles are indexed [row][col]
  typedef a_elem_t [`MM_TILE_DIM-1:0][`MM_TILE_DIM-1:0] a_tile_t;
  typedef b_elem_t [`MM_TILE_DIM-1:0][`MM_TILE_DIM-1:0] b_tile_t;
  typedef prod_elem_t [`MM_TILE_DIM-1:0][`MM_TILE_DIM-1:0] prod_tile_t;
  typedef acc_elem_t [`MM_TILE_DIM-1:0][`MM_TILE_DIM-1:0] acc_tile_t;
  typedef c_elem_t [`MM_TILE_DIM-1:0][`MM_TILE_DIM-1:0] c_tile_t;

endpackage

/* hdl/matmul_ctrl_pkg.sv */
// **************************************************
// Control types: FSM states, configuration opcodes
// and the output cast settings
// **************************************************

package matmul_ctrl_pkg;

  // B buffer: storing a new matrix or replaying it
  typedef enum logic {
    FILL,
    REPLAY
  } buf_state_e;

  // Accumulator: collecting products or waiting to drain
  typedef enum logic {
    SUM,
    DRAIN
  } acc_state_e;

  // Configuration port opcodes
  typedef enum logic {
    CFG_SET_SHIFT,
    CFG_SET_MODE
  } cfg_op_e;

  typedef struct packed {
    logic [1:0] shift;
    logic       symmetric;
  } cast_cfg_t;

endpackage

/* hdl/a_tile_repeater.sv */
// **************************************************
// Holds each A tile and presents it once per B tile
// column, so every A tile meets a full B tile row
// **************************************************
`timescale 1ns/10ps
`include "matmul_consts.svh"

module a_tile_repeater (
  input  logic                     clk,
  input  logic                     rst,
  input  matmul_data_pkg::a_tile_t a_tile,
  input  logic                     a_valid,
  output logic                     a_ready,
  output matmul_data_pkg::a_tile_t rep_tile,
  output logic                     rep_valid,
  input  logic                     rep_ready
);

  localparam int CNT_W = $clog2(`MM_TILE_DEPTH);

  logic [CNT_W-1:0] copy_cnt;
  logic             last_copy;

  assign last_copy = (copy_cnt == CNT_W'(`MM_TILE_DEPTH - 1));

  // Holding register, loaded only on acceptance
  always_ff @(posedge clk) begin
    if (a_valid && a_ready) begin
      rep_tile <= a_tile;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      a_ready   <= 1'b0;
      rep_valid <= 1'b0;
      copy_cnt  <= '0;
    end else if (a_valid && a_ready) begin
      a_ready   <= 1'b0;
      rep_valid <= 1'b1;
      copy_cnt  <= '0;
    end else if (rep_valid && rep_ready) begin
      // Free the register only once the last copy has gone out
      if (last_copy) begin
        rep_valid <= 1'b0;
        a_ready   <= 1'b1;
        copy_cnt  <= '0;
      end else begin
        copy_cnt <= copy_cnt + 1'b1;
      end
    end else if (!rep_valid) begin
      a_ready <= 1'b1;
    end
  end

  // A copy waiting under back-pressure keeps its value
  rep_hold_stable: assert property (@(posedge clk) disable iff (rst)
    rep_valid && !rep_ready |=> $stable(rep_tile));

endmodule

/* hdl/b_tile_buffer.sv */
// **************************************************
// Stores the B tiles of one matrix while forwarding
// them, then replays them for each further A tile row
// **************************************************
`timescale 1ns/10ps
`include "matmul_consts.svh"

module b_tile_buffer (
  input  logic                     clk,
  input  logic                     rst,
  input  matmul_data_pkg::b_tile_t b_tile,
  input  logic                     b_valid,
  output logic                     b_ready,
  output matmul_data_pkg::b_tile_t buf_tile,
  output logic                     buf_valid,
  input  logic                     buf_ready
);

  import matmul_data_pkg::*;
  import matmul_ctrl_pkg::*;

  localparam int PTR_W  = $clog2(`MM_B_TILES);
  localparam int PASS_W = $clog2(`MM_TILE_DEPTH);

  b_tile_t           tile_mem [`MM_B_TILES];
  buf_state_e        state;
  logic [PTR_W-1:0]  tile_ptr;
  logic [PASS_W-1:0] pass_cnt;
  logic              armed;
  logic              out_free;
  logic              last_tile;
  logic              wr_en;
  logic              rd_en;

  assign out_free  = !buf_valid || buf_ready;
  assign last_tile = (tile_ptr == PTR_W'(`MM_B_TILES - 1));
  // armed keeps b_ready low through reset
  assign b_ready   = armed && (state == FILL) && out_free;
  assign wr_en     = b_valid && b_ready;
  assign rd_en     = (state == REPLAY) && out_free;

  // Incoming tiles go to memory and straight to the output
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tile_mem[tile_ptr] <= b_tile;
      buf_tile           <= b_tile;
    end else if (rd_en) begin
      buf_tile <= tile_mem[tile_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      armed     <= 1'b0;
      state     <= FILL;
      tile_ptr  <= '0;
      pass_cnt  <= '0;
      buf_valid <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (wr_en || rd_en) begin
        buf_valid <= 1'b1;
        if (last_tile) begin
          tile_ptr <= '0;
          // The fill itself counts as the first pass
          if (state == FILL) begin
            state    <= REPLAY;
            pass_cnt <= PASS_W'(1);
          end else if (pass_cnt == PASS_W'(`MM_TILE_DEPTH - 1)) begin
            state    <= FILL;
            pass_cnt <= '0;
          end else begin
            pass_cnt <= pass_cnt + 1'b1;
          end
        end else begin
          tile_ptr <= tile_ptr + 1'b1;
        end
      end else if (buf_valid && buf_ready) begin
        buf_valid <= 1'b0;
      end
    end
  end

  // Stored tiles are never overwritten while being replayed
  no_replay_write: assert property (@(posedge clk) disable iff (rst)
    state == REPLAY |-> !wr_en);

endmodule

/* hdl/tile_multiplier.sv */
// **************************************************
// Multiplies a repeated A tile by a buffered B tile
// into one registered full precision product tile
// **************************************************
`timescale 1ns/10ps
`include "matmul_consts.svh"

module tile_multiplier (
  input  logic                        clk,
  input  logic                        rst,
  input  matmul_data_pkg::a_tile_t    rep_tile,
  input  logic                        rep_valid,
  output logic                        rep_ready,
  input  matmul_data_pkg::b_tile_t    buf_tile,
  input  logic                        buf_valid,
  output logic                        buf_ready,
  output matmul_data_pkg::prod_tile_t prod_tile,
  output logic                        prod_valid,
  input  logic                        prod_ready
);

  import matmul_data_pkg::*;

  prod_tile_t prod_next;
  logic       stage_free;
  logic       take;

  // Both inputs move together, so each ready waits on the other valid
  assign stage_free = !prod_valid || prod_ready;
  assign rep_ready  = stage_free && buf_valid;
  assign buf_ready  = stage_free && rep_valid;
  assign take       = rep_valid && buf_valid && stage_free;

  always_comb begin
    prod_elem_t term;
    for (int r = 0; r < `MM_TILE_DIM; r++) begin
      for (int c = 0; c < `MM_TILE_DIM; c++) begin
        prod_next[r][c] = '0;
        for (int m = 0; m < `MM_TILE_DIM; m++) begin
          // Widened before the multiply, so no bits are lost
          term            = rep_tile[r][m] * buf_tile[m][c];
          prod_next[r][c] = prod_next[r][c] + term;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      prod_tile <= prod_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
    end else if (take) begin
      prod_valid <= 1'b1;
    end else if (prod_ready) begin
      prod_valid <= 1'b0;
    end
  end

endmodule

/* hdl/accumulator_bank.sv */
// **************************************************
// Sums tile products per C tile column, then drains
// the finished tiles in order through the output cast
// **************************************************
`timescale 1ns/10ps
`include "matmul_consts.svh"

module accumulator_bank (
  input  logic                        clk,
  input  logic                        rst,
  input  matmul_data_pkg::prod_tile_t prod_tile,
  input  logic                        prod_valid,
  output logic                        prod_ready,
  input  matmul_ctrl_pkg::cast_cfg_t  cfg,
  output matmul_data_pkg::c_tile_t    c_tile,
  output logic                        c_valid,
  input  logic                        c_ready
);

  import matmul_data_pkg::*;
  import matmul_ctrl_pkg::*;

  localparam int PTR_W = $clog2(`MM_TILE_DEPTH);
  // Product sums carry twice the input fraction
  localparam int FRAC_DROP = 2 * `MM_IN_FRAC - `MM_OUT_FRAC;
  localparam acc_elem_t SAT_MAX = acc_elem_t'((1 << (`MM_OUT_WIDTH - 1)) - 1);
  localparam acc_elem_t SAT_MIN = acc_elem_t'(-(1 << (`MM_OUT_WIDTH - 1)));
  localparam acc_elem_t SAT_MIN_SYM = acc_elem_t'(-(1 << (`MM_OUT_WIDTH - 1)) + 1);

  acc_tile_t        acc_q     [`MM_TILE_DEPTH];
  acc_state_e       acc_state [`MM_TILE_DEPTH];
  logic [PTR_W-1:0] acc_cnt   [`MM_TILE_DEPTH];
  logic [PTR_W-1:0] in_ptr;
  logic [PTR_W-1:0] out_ptr;
  logic             prod_take;
  logic             c_take;
  acc_elem_t        sat_min;

  // Stall products aimed at a tile that has not drained yet
  assign prod_ready = (acc_state[in_ptr] == SUM);
  assign prod_take  = prod_valid && prod_ready;
  assign c_valid    = (acc_state[out_ptr] == DRAIN);
  assign c_take     = c_valid && c_ready;
  assign sat_min    = cfg.symmetric ? SAT_MIN_SYM : SAT_MIN;

  // First product of a C tile loads, later ones add
  always_ff @(posedge clk) begin
    if (prod_take) begin
      for (int r = 0; r < `MM_TILE_DIM; r++) begin
        for (int c = 0; c < `MM_TILE_DIM; c++) begin
          if (acc_cnt[in_ptr] == '0) begin
            acc_q[in_ptr][r][c] <= prod_tile[r][c];
          end else begin
            acc_q[in_ptr][r][c] <= acc_q[in_ptr][r][c] + prod_tile[r][c];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ptr  <= '0;
      out_ptr <= '0;
      for (int i = 0; i < `MM_TILE_DEPTH; i++) begin
        acc_state[i] <= SUM;
        acc_cnt[i]   <= '0;
      end
    end else begin
      if (prod_take) begin
        in_ptr <= (in_ptr == PTR_W'(`MM_TILE_DEPTH - 1)) ? '0 : in_ptr + 1'b1;
        if (acc_cnt[in_ptr] == PTR_W'(`MM_TILE_DEPTH - 1)) begin
          acc_cnt[in_ptr]   <= '0;
          acc_state[in_ptr] <= DRAIN;
        end else begin
          acc_cnt[in_ptr] <= acc_cnt[in_ptr] + 1'b1;
        end
      end
      if (c_take) begin
        acc_state[out_ptr] <= SUM;
        out_ptr <= (out_ptr == PTR_W'(`MM_TILE_DEPTH - 1)) ? '0 : out_ptr + 1'b1;
      end
    end
  end

  // Floor shift then saturate to the output width
  always_comb begin
    acc_elem_t shifted;
    for (int r = 0; r < `MM_TILE_DIM; r++) begin
      for (int c = 0; c < `MM_TILE_DIM; c++) begin
        shifted = acc_q[out_ptr][r][c] >>> (FRAC_DROP + cfg.shift);
        if (shifted > SAT_MAX) begin
          c_tile[r][c] = c_elem_t'(SAT_MAX);
        end else if (shifted < sat_min) begin
          c_tile[r][c] = c_elem_t'(sat_min);
        end else begin
          c_tile[r][c] = c_elem_t'(shifted);
        end
      end
    end
  end

  ptr_range: assert property (@(posedge clk) disable iff (rst)
    (in_ptr <= PTR_W'(`MM_TILE_DEPTH - 1)) && (out_ptr <= PTR_W'(`MM_TILE_DEPTH - 1)));

endmodule

/* hdl/cast_config.sv */
// **************************************************
// Output cast settings, written over a four-phase
// req/ack port while the pipeline is idle
// **************************************************
`timescale 1ns/10ps

module cast_config (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfg_req,
  input  matmul_ctrl_pkg::cfg_op_e   cfg_op,
  input  logic [1:0]                 cfg_data,
  output logic                       cfg_ack,
  output matmul_ctrl_pkg::cast_cfg_t cfg
);

  import matmul_ctrl_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_ack <= 1'b0;
      cfg     <= '0;
    end else if (cfg_req && !cfg_ack) begin
      // Phase 2, write once then acknowledge
      cfg_ack <= 1'b1;
      case (cfg_op)
        CFG_SET_SHIFT: cfg.shift     <= cfg_data;
        CFG_SET_MODE:  cfg.symmetric <= cfg_data[0];
        default:       cfg           <= cfg;
      endcase
    end else if (!cfg_req && cfg_ack) begin
      // Phase 4, release after the master drops req
      cfg_ack <= 1'b0;
    end
  end

  // An acknowledge always answers a request seen the cycle before
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cfg_ack) |-> $past(cfg_req));

endmodule

/* hdl/matmul.sv */
// **************************************************
// Streaming tiled matrix multiply C = A*B, with
// valid/ready tile streams and a req/ack cast setup
// **************************************************
`timescale 1ns/10ps

module matmul (
  input  logic                     clk,
  input  logic                     rst,
  input  matmul_data_pkg::a_tile_t a_tile,
  input  logic                     a_valid,
  output logic                     a_ready,
  input  matmul_data_pkg::b_tile_t b_tile,
  input  logic                     b_valid,
  output logic                     b_ready,
  output matmul_data_pkg::c_tile_t c_tile,
  output logic                     c_valid,
  input  logic                     c_ready,
  input  logic                     cfg_req,
  input  matmul_ctrl_pkg::cfg_op_e cfg_op,
  input  logic [1:0]               cfg_data,
  output logic                     cfg_ack
);

  import matmul_data_pkg::*;
  import matmul_ctrl_pkg::*;

  a_tile_t    rep_tile;
  logic       rep_valid;
  logic       rep_ready;
  b_tile_t    buf_tile;
  logic       buf_valid;
  logic       buf_ready;
  prod_tile_t prod_tile;
  logic       prod_valid;
  logic       prod_ready;
  cast_cfg_t  cfg;

  a_tile_repeater a_rep_inst (
    .clk       (clk),
    .rst       (rst),
    .a_tile    (a_tile),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .rep_tile  (rep_tile),
    .rep_valid (rep_valid),
    .rep_ready (rep_ready)
  );

  b_tile_buffer b_buf_inst (
    .clk       (clk),
    .rst       (rst),
    .b_tile    (b_tile),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .buf_tile  (buf_tile),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready)
  );

  tile_multiplier mult_inst (
    .clk        (clk),
    .rst        (rst),
    .rep_tile   (rep_tile),
    .rep_valid  (rep_valid),
    .rep_ready  (rep_ready),
    .buf_tile   (buf_tile),
    .buf_valid  (buf_valid),
    .buf_ready  (buf_ready),
    .prod_tile  (prod_tile),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready)
  );

  accumulator_bank acc_inst (
    .clk        (clk),
    .rst        (rst),
    .prod_tile  (prod_tile),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .cfg        (cfg),
    .c_tile     (c_tile),
    .c_valid    (c_valid),
    .c_ready    (c_ready)
  );

  cast_config cfg_inst (
    .clk      (clk),
    .rst      (rst),
    .cfg_req  (cfg_req),
    .cfg_op   (cfg_op),
    .cfg_data (cfg_data),
    .cfg_ack  (cfg_ack),
    .cfg      (cfg)
  );

endmodule

/* verification/matmul_tb.sv */
// **************************************************
// Directed testbench for the tiled matrix multiplier.
// Streams A and B tiles, collects C tiles and compares
// them with an integer reference model
// **************************************************
`timescale 1ns/10ps
`include "matmul_consts.svh"

module matmul_tb;

  import matmul_data_pkg::*;
  import matmul_ctrl_pkg::*;

  localparam int N = `MM_TOTAL_DIM;
  localparam int T = `MM_TILE_DIM;
  localparam int D = `MM_TILE_DEPTH;
  localparam int WAIT_LIMIT = 1000;

  logic       clk = 1'b0;
  logic       rst;
  a_tile_t    a_tile;
  logic       a_valid;
  logic       a_ready;
  b_tile_t    b_tile;
  logic       b_valid;
  logic       b_ready;
  c_tile_t    c_tile;
  logic       c_valid;
  logic       c_ready;
  logic       cfg_req;
  cfg_op_e    cfg_op;
  logic [1:0] cfg_data;
  logic       cfg_ack;

  // Raw fixed-point values for up to two products per run
  int          a_m   [2][N][N];
  int          b_m   [2][N][N];
  int          exp_c [2][N][N];
  int          cur_shift;
  bit          cur_sym;
  logic [31:0] rng_state;

  matmul matmul_inst (
    .clk      (clk),
    .rst      (rst),
    .a_tile   (a_tile),
    .a_valid  (a_valid),
    .a_ready  (a_ready),
    .b_tile   (b_tile),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .c_tile   (c_tile),
    .c_valid  (c_valid),
    .c_ready  (c_ready),
    .cfg_req  (cfg_req),
    .cfg_op   (cfg_op),
    .cfg_data (cfg_data),
    .cfg_ack  (cfg_ack)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int next_byte();
    rng_state = lcg_step(rng_state);
    return int'($signed(rng_state[31:24]));
  endfunction

  task automatic check(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic stall_abort(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stalled");
  endtask

  function automatic void fill_random(input int p);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        a_m[p][i][j] = next_byte();
        b_m[p][i][j] = next_byte();
      end
    end
  endfunction

  function automatic void set_constant(input int p, input int av, input int bv);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        a_m[p][i][j] = av;
        b_m[p][i][j] = bv;
      end
    end
  endfunction

  function automatic void fill_expected(input int p, input int v);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        exp_c[p][i][j] = v;
      end
    end
  endfunction

  // Odd negative A times a diagonal of odd B gives odd negative sums
  function automatic void odd_pattern(input int p);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        a_m[p][i][j] = -(2 * (i + j) + 1);
        b_m[p][i][j] = (i == j) ? (2 * j + 3) : 0;
      end
    end
  endfunction

  // Reference model does a raw integer product, a floor shift and saturation
  function automatic void model_product(input int p);
    int sum;
    int lo;
    lo = cur_sym ? -32767 : -32768;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        sum = 0;
        for (int k = 0; k < N; k++) begin
          sum += a_m[p][i][k] * b_m[p][k][j];
        end
        sum = sum >>> cur_shift;
        if (sum > 32767) begin
          exp_c[p][i][j] = 32767;
        end else if (sum < lo) begin
          exp_c[p][i][j] = lo;
        end else begin
          exp_c[p][i][j] = sum;
        end
      end
    end
  endfunction

  // Four-phase write with ack one cycle after each req edge
  task automatic cfg_write(input cfg_op_e op, input logic [1:0] data);
    int cnt;
    cfg_op   <= op;
    cfg_data <= data;
    cfg_req  <= 1'b1;
    @(negedge clk);
    check("cfg_ack before write", 0, int'(cfg_ack));
    cnt = 0;
    while (!cfg_ack) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        stall_abort("cfg_ack never rose after cfg_req");
      end
    end
    check("cfg_ack rise delay", 1, cnt);
    @(posedge clk);
    cfg_req <= 1'b0;
    @(negedge clk);
    check("cfg_ack held", 1, int'(cfg_ack));
    cnt = 0;
    while (cfg_ack) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        stall_abort("cfg_ack never fell after cfg_req dropped");
      end
    end
    check("cfg_ack fall delay", 1, cnt);
    @(posedge clk);
    if (op == CFG_SET_SHIFT) begin
      cur_shift = int'(data);
    end else begin
      cur_sym = data[0];
    end
  endtask

  // A tiles (i,k) with k fastest
  task automatic drive_a(input int n, input bit bp, input logic [31:0] seed);
    a_tile_t     t;
    logic [31:0] s;
    int          cnt;
    s = seed;
    for (int p = 0; p < n; p++) begin
      for (int ti = 0; ti < D; ti++) begin
        for (int tk = 0; tk < D; tk++) begin
          for (int r = 0; r < T; r++) begin
            for (int c = 0; c < T; c++) begin
              t[r][c] = a_elem_t'(a_m[p][ti*T+r][tk*T+c]);
            end
          end
          s = lcg_step(s);
          if (bp && s[31:30] != 2'd0) begin
            a_valid <= 1'b0;
            repeat (s[31:30]) @(posedge clk);
          end
          a_tile  <= t;
          a_valid <= 1'b1;
          cnt = 0;
          do begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
              stall_abort("A tile was never accepted");
            end
          end while (!a_ready);
          @(posedge clk);
        end
      end
    end
    a_valid <= 1'b0;
  endtask

  // B tiles (k,j) with j fastest
  task automatic drive_b(input int n, input bit bp, input logic [31:0] seed);
    b_tile_t     t;
    logic [31:0] s;
    int          cnt;
    s = seed;
    for (int p = 0; p < n; p++) begin
      for (int tk = 0; tk < D; tk++) begin
        for (int tj = 0; tj < D; tj++) begin
          for (int r = 0; r < T; r++) begin
            for (int c = 0; c < T; c++) begin
              t[r][c] = b_elem_t'(b_m[p][tk*T+r][tj*T+c]);
            end
          end
          s = lcg_step(s);
          if (bp && s[31:30] != 2'd0) begin
            b_valid <= 1'b0;
            repeat (s[31:30]) @(posedge clk);
          end
          b_tile  <= t;
          b_valid <= 1'b1;
          cnt = 0;
          do begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
              stall_abort("B tile was never accepted");
            end
          end while (!b_ready);
          @(posedge clk);
        end
      end
    end
    b_valid <= 1'b0;
  endtask

  task automatic collect_c(input int n, input bit bp, input logic [31:0] seed);
    logic [31:0] s;
    int          cnt;
    bit          got;
    s = seed;
    for (int p = 0; p < n; p++) begin
      for (int ti = 0; ti < D; ti++) begin
        for (int tj = 0; tj < D; tj++) begin
          cnt = 0;
          got = 1'b0;
          while (!got) begin
            s = lcg_step(s);
            c_ready <= bp ? s[31] : 1'b1;
            @(negedge clk);
            if (c_valid && c_ready) begin
              got = 1'b1;
              for (int r = 0; r < T; r++) begin
                for (int c = 0; c < T; c++) begin
                  check($sformatf("c_tile[%0d][%0d] of C(%0d,%0d) product %0d",
                                  r, c, ti, tj, p),
                        exp_c[p][ti*T+r][tj*T+c], int'(c_tile[r][c]));
                end
              end
            end else begin
              cnt++;
              if (cnt > WAIT_LIMIT) begin
                stall_abort("C tile never became valid");
              end
            end
            @(posedge clk);
          end
        end
      end
    end
    c_ready <= 1'b0;
  endtask

  task automatic run_products(input int n, input bit bp);
    logic [31:0] sa;
    logic [31:0] sb;
    logic [31:0] sc;
    rng_state = lcg_step(rng_state);
    sa = rng_state;
    rng_state = lcg_step(rng_state);
    sb = rng_state;
    rng_state = lcg_step(rng_state);
    sc = rng_state;
    fork
      drive_a(n, bp, sa);
      drive_b(n, bp, sb);
      collect_c(n, bp, sc);
    join
    // No extra tile may follow the last expected one
    repeat (3) begin
      @(negedge clk);
      check("c_valid after last tile", 0, int'(c_valid));
    end
    @(posedge clk);
  endtask

  // A is 2.0 times identity and B(r,c) = 4r+c, so C = 2B with two fractional bits
  task automatic known_matrices();
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        a_m[0][i][j]   = (i == j) ? 4 : 0;
        b_m[0][i][j]   = 2 * (N * i + j);
        exp_c[0][i][j] = 8 * (N * i + j);
      end
    end
    run_products(1, 1'b0);
  endtask

  task automatic random_matrices();
    fill_random(0);
    model_product(0);
    run_products(1, 1'b0);
  endtask

  task automatic back_pressure();
    fill_random(0);
    fill_random(1);
    model_product(0);
    model_product(1);
    run_products(2, 1'b1);
  endtask

  task automatic saturation();
    cfg_write(CFG_SET_MODE, 2'd0);
    set_constant(0, -128, -128);
    fill_expected(0, 32767);
    set_constant(1, -128, 127);
    fill_expected(1, -32768);
    run_products(2, 1'b0);
    cfg_write(CFG_SET_MODE, 2'd1);
    fill_expected(1, -32767);
    run_products(2, 1'b0);
    cfg_write(CFG_SET_MODE, 2'd0);
  endtask

  task automatic floor_shift();
    cfg_write(CFG_SET_SHIFT, 2'd1);
    odd_pattern(0);
    model_product(0);
    run_products(1, 1'b0);
    cfg_write(CFG_SET_SHIFT, 2'd3);
    odd_pattern(0);
    fill_random(1);
    model_product(0);
    model_product(1);
    run_products(2, 1'b0);
    cfg_write(CFG_SET_SHIFT, 2'd0);
  endtask

  // Same A twice with a new B for the second product
  task automatic back_to_back();
    fill_random(0);
    fill_random(1);
    a_m[1] = a_m[0];
    model_product(0);
    model_product(1);
    run_products(2, 1'b0);
  endtask

  initial begin
    rst       = 1'b1;
    a_tile    = '0;
    a_valid   = 1'b0;
    b_tile    = '0;
    b_valid   = 1'b0;
    c_ready   = 1'b0;
    cfg_req   = 1'b0;
    cfg_op    = CFG_SET_SHIFT;
    cfg_data  = 2'd0;
    cur_shift = 0;
    cur_sym   = 1'b0;
    rng_state = 32'h14f828b8;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    known_matrices();
    random_matrices();
    back_pressure();
    saturation();
    floor_shift();
    back_to_back();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/matmul_data_pkg.sv
hdl/matmul_ctrl_pkg.sv
hdl/a_tile_repeater.sv
hdl/b_tile_buffer.sv
hdl/tile_multiplier.sv
hdl/accumulator_bank.sv
hdl/cast_config.sv
hdl/matmul.sv
verification/matmul_tb.sv
